// ==== common/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // register field positions in the instruction word
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int RD_LSB  = 7;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes, anything else is decoded as a bubble
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10   // lui
    } alu_op_e;

    // operand source for each register read
    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_EXE = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

endpackage

`default_nettype wire

// ==== decode/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire core_pkg::reg_addr_t  rs1_addr_i,
    input  wire core_pkg::reg_addr_t  rs2_addr_i,
    output core_pkg::word_t           rs1_data_o,
    output core_pkg::word_t           rs2_data_o,
    input  wire                       we_i,
    input  wire core_pkg::reg_addr_t  waddr_i,
    input  wire core_pkg::word_t      wdata_i
);

    core_pkg::word_t mem [core_pkg::NUM_REGS];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (we_i && (waddr_i != '0)) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // registered read, returns the value from before a same-edge write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rs1_data_o <= '0;
            rs2_data_o <= '0;
        end else begin
            rs1_data_o <= (rs1_addr_i == '0) ? '0 : mem[rs1_addr_i];
            rs2_data_o <= (rs2_addr_i == '0) ? '0 : mem[rs2_addr_i];
        end
    end

endmodule

`default_nettype wire

// ==== decode/operand_fwd.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_fwd (
    input  wire core_pkg::reg_addr_t  rs1_i,
    input  wire core_pkg::reg_addr_t  rs2_i,
    input  wire core_pkg::word_t      rf_rs1_i,
    input  wire core_pkg::word_t      rf_rs2_i,
    input  wire core_pkg::word_t      exe_result_i,
    input  wire core_pkg::reg_addr_t  exe_rd_i,
    input  wire                       exe_wen_i,
    input  wire core_pkg::word_t      wb_data_i,
    input  wire core_pkg::reg_addr_t  wb_rd_i,
    input  wire                       wb_valid_i,
    output core_pkg::word_t           op_rs1_o,
    output core_pkg::word_t           op_rs2_o
);

    core_pkg::fwd_sel_e rs1_sel;
    core_pkg::fwd_sel_e rs2_sel;

    // youngest producer wins, x0 always comes from the register file
    function automatic core_pkg::fwd_sel_e pick_src(input core_pkg::reg_addr_t rs);
        core_pkg::fwd_sel_e sel;
        if (rs == '0) begin
            sel = core_pkg::FWD_RF;
        end else if (exe_wen_i && (exe_rd_i == rs)) begin
            sel = core_pkg::FWD_EXE;
        end else if (wb_valid_i && (wb_rd_i == rs)) begin
            sel = core_pkg::FWD_WB;
        end else begin
            sel = core_pkg::FWD_RF;
        end
        return sel;
    endfunction

    assign rs1_sel = pick_src(rs1_i);
    assign rs2_sel = pick_src(rs2_i);

    always_comb begin
        case (rs1_sel)
            core_pkg::FWD_EXE: op_rs1_o = exe_result_i;
            core_pkg::FWD_WB:  op_rs1_o = wb_data_i;
            default:           op_rs1_o = rf_rs1_i;
        endcase
    end

    always_comb begin
        case (rs2_sel)
            core_pkg::FWD_EXE: op_rs2_o = exe_result_i;
            core_pkg::FWD_WB:  op_rs2_o = wb_data_i;
            default:           op_rs2_o = rf_rs2_i;
        endcase
    end

endmodule

`default_nettype wire

// ==== decode/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       inst_valid_i,
    input  wire core_pkg::word_t      inst_i,
    input  wire                       stall_i,
    input  wire core_pkg::word_t      exe_result_i,
    input  wire core_pkg::reg_addr_t  exe_rd_i,
    input  wire                       exe_wen_i,
    input  wire core_pkg::word_t      wb_data_i,
    input  wire core_pkg::reg_addr_t  wb_rd_i,
    input  wire                       wb_valid_i,
    input  wire                       rf_we_i,
    input  wire core_pkg::reg_addr_t  rf_waddr_i,
    input  wire core_pkg::word_t      rf_wdata_i,
    output core_pkg::word_t           op_a_o,
    output core_pkg::word_t           op_b_o,
    output core_pkg::alu_op_e         alu_op_o,
    output core_pkg::reg_addr_t       rd_o,
    output logic                      wen_o
);

    core_pkg::word_t    fetch_inst;
    core_pkg::word_t    dec_inst_q;
    core_pkg::word_t    rf_rs1_data;
    core_pkg::word_t    rf_rs2_data;
    core_pkg::word_t    fwd_rs2;
    core_pkg::word_t    imm_i;
    core_pkg::word_t    imm_u;
    core_pkg::opcode_e  opcode;
    logic [2:0]         funct3;

    function automatic core_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                                     input logic is_reg);
        core_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = (is_reg && alt) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  op = core_pkg::ALU_SLL;
            3'b010:  op = core_pkg::ALU_SLT;
            3'b011:  op = core_pkg::ALU_SLTU;
            3'b100:  op = core_pkg::ALU_XOR;
            3'b101:  op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  op = core_pkg::ALU_OR;
            default: op = core_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    // next decode word is the held word while stalled
    always_comb begin
        if (stall_i) begin
            fetch_inst = dec_inst_q;
        end else if (inst_valid_i) begin
            fetch_inst = inst_i;
        end else begin
            fetch_inst = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_inst_q <= '0;
        end else begin
            dec_inst_q <= fetch_inst;
        end
    end

    // read addresses come from the incoming word so data lines up with dec_inst_q
    regfile i_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (fetch_inst[core_pkg::RS1_LSB +: core_pkg::REG_ADDR_W]),
        .rs2_addr_i (fetch_inst[core_pkg::RS2_LSB +: core_pkg::REG_ADDR_W]),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data),
        .we_i       (rf_we_i),
        .waddr_i    (rf_waddr_i),
        .wdata_i    (rf_wdata_i)
    );

    operand_fwd i_operand_fwd (
        .rs1_i        (dec_inst_q[core_pkg::RS1_LSB +: core_pkg::REG_ADDR_W]),
        .rs2_i        (dec_inst_q[core_pkg::RS2_LSB +: core_pkg::REG_ADDR_W]),
        .rf_rs1_i     (rf_rs1_data),
        .rf_rs2_i     (rf_rs2_data),
        .exe_result_i (exe_result_i),
        .exe_rd_i     (exe_rd_i),
        .exe_wen_i    (exe_wen_i),
        .wb_data_i    (wb_data_i),
        .wb_rd_i      (wb_rd_i),
        .wb_valid_i   (wb_valid_i),
        .op_rs1_o     (op_a_o),
        .op_rs2_o     (fwd_rs2)
    );

    assign opcode   = core_pkg::opcode_e'(dec_inst_q[6:0]);
    assign funct3   = dec_inst_q[14:12];
    assign rd_o     = dec_inst_q[core_pkg::RD_LSB +: core_pkg::REG_ADDR_W];

    // immediates
    assign imm_i = {{(core_pkg::XLEN-12){dec_inst_q[31]}}, dec_inst_q[31:20]};
    assign imm_u = {dec_inst_q[31:12], 12'b0};

    always_comb begin
        alu_op_o = core_pkg::ALU_ADD;
        wen_o    = 1'b0;
        op_b_o   = fwd_rs2;
        case (opcode)
            core_pkg::OPC_OP: begin
                alu_op_o = alu_decode(funct3, dec_inst_q[30], 1'b1);
                wen_o    = 1'b1;
            end
            core_pkg::OPC_OP_IMM: begin
                alu_op_o = alu_decode(funct3, dec_inst_q[30], 1'b0);
                wen_o    = 1'b1;
                // shift amount is imm_i[4:0], execute reads only those bits
                op_b_o   = imm_i;
            end
            core_pkg::OPC_LUI: begin
                alu_op_o = core_pkg::ALU_PASS_B;
                wen_o    = 1'b1;
                op_b_o   = imm_u;
            end
            default: begin
                // illegal opcodes and bubbles leave no trace downstream
                wen_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/exe_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       stall_i,
    input  wire core_pkg::word_t      op_a_i,
    input  wire core_pkg::word_t      op_b_i,
    input  wire core_pkg::alu_op_e    alu_op_i,
    input  wire core_pkg::reg_addr_t  rd_i,
    input  wire                       wen_i,
    output core_pkg::word_t           exe_result_o,
    output core_pkg::reg_addr_t       exe_rd_o,
    output logic                      exe_wen_o,
    output logic                      rf_we_o,
    output logic                      wb_valid_o,
    output core_pkg::reg_addr_t       wb_rd_o,
    output core_pkg::word_t           wb_data_o
);

    core_pkg::word_t   op_a_q;
    core_pkg::word_t   op_b_q;
    core_pkg::alu_op_e alu_op_q;
    logic [4:0]        shamt;

    // execute row
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe_wen_o <= 1'b0;
        end else if (!stall_i) begin
            exe_wen_o <= wen_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            op_a_q   <= op_a_i;
            op_b_q   <= op_b_i;
            alu_op_q <= alu_op_i;
            exe_rd_o <= rd_i;
        end
    end

    assign shamt = op_b_q[4:0];

    always_comb begin
        case (alu_op_q)
            core_pkg::ALU_ADD:    exe_result_o = op_a_q + op_b_q;
            core_pkg::ALU_SUB:    exe_result_o = op_a_q - op_b_q;
            core_pkg::ALU_SLL:    exe_result_o = op_a_q << shamt;
            core_pkg::ALU_SLT:    exe_result_o = {31'b0, $signed(op_a_q) < $signed(op_b_q)};
            core_pkg::ALU_SLTU:   exe_result_o = {31'b0, op_a_q < op_b_q};
            core_pkg::ALU_XOR:    exe_result_o = op_a_q ^ op_b_q;
            core_pkg::ALU_SRL:    exe_result_o = op_a_q >> shamt;
            core_pkg::ALU_SRA:    exe_result_o = core_pkg::word_t'($signed(op_a_q) >>> shamt);
            core_pkg::ALU_OR:     exe_result_o = op_a_q | op_b_q;
            core_pkg::ALU_AND:    exe_result_o = op_a_q & op_b_q;
            core_pkg::ALU_PASS_B: exe_result_o = op_b_q;
            default:              exe_result_o = '0;
        endcase
    end

    // write lands at the end of execute, never while frozen
    assign rf_we_o = exe_wen_o && !stall_i;

    // writeback row
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid_o <= 1'b0;
        end else if (stall_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= exe_wen_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wb_rd_o   <= exe_rd_o;
            wb_data_o <= exe_result_o;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/int_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_pipe (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       inst_valid_i,
    input  wire core_pkg::word_t      inst_i,
    input  wire                       stall_i,
    output logic                      wb_valid_o,
    output core_pkg::reg_addr_t       wb_rd_o,
    output core_pkg::word_t           wb_data_o
);

    core_pkg::word_t     op_a;
    core_pkg::word_t     op_b;
    core_pkg::alu_op_e   alu_op;
    core_pkg::reg_addr_t dec_rd;
    logic                dec_wen;
    core_pkg::word_t     exe_result;
    core_pkg::reg_addr_t exe_rd;
    logic                exe_wen;
    logic                rf_we;

    decode_stage i_decode_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .stall_i      (stall_i),
        .exe_result_i (exe_result),
        .exe_rd_i     (exe_rd),
        .exe_wen_i    (exe_wen),
        .wb_data_i    (wb_data_o),
        .wb_rd_i      (wb_rd_o),
        .wb_valid_i   (wb_valid_o),
        .rf_we_i      (rf_we),
        .rf_waddr_i   (exe_rd),
        .rf_wdata_i   (exe_result),
        .op_a_o       (op_a),
        .op_b_o       (op_b),
        .alu_op_o     (alu_op),
        .rd_o         (dec_rd),
        .wen_o        (dec_wen)
    );

    // writeback row drives the output ports directly
    exe_stage i_exe_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_i      (stall_i),
        .op_a_i       (op_a),
        .op_b_i       (op_b),
        .alu_op_i     (alu_op),
        .rd_i         (dec_rd),
        .wen_i        (dec_wen),
        .exe_result_o (exe_result),
        .exe_rd_o     (exe_rd),
        .exe_wen_o    (exe_wen),
        .rf_we_o      (rf_we),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

endmodule

`default_nettype wire

// ==== test/tb_int_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_int_pipe;

    logic                clk;
    logic                rst_n;
    logic                inst_valid_i;
    core_pkg::word_t     inst_i;
    logic                stall_i;
    logic                wb_valid_o;
    core_pkg::reg_addr_t wb_rd_o;
    core_pkg::word_t     wb_data_o;

    logic [15:0]         lfsr;
    core_pkg::word_t     model_regs [32];
    core_pkg::reg_addr_t exp_rd_q [$];
    core_pkg::word_t     exp_data_q [$];
    int                  exp_tag_q [$];
    int                  run_edges;
    int                  errors;
    int                  checks;
    int                  tests;
    logic                stall_en;

    int_pipe i_int_pipe (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .stall_i      (stall_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci lfsr with taps 16 14 13 11 and one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic core_pkg::reg_addr_t pick_reg(input int n);
        return core_pkg::reg_addr_t'(rand_bits(n));
    endfunction

    function automatic logic is_legal(input core_pkg::word_t inst);
        return (inst[6:0] == 7'b0110011) || (inst[6:0] == 7'b0010011) ||
               (inst[6:0] == 7'b0110111);
    endfunction

    // architectural result per the RV32I rules
    function automatic core_pkg::word_t golden(input core_pkg::word_t inst);
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::word_t r;
        logic            reg_op;
        reg_op = (inst[6:0] == 7'b0110011);
        a = model_regs[inst[19:15]];
        b = reg_op ? model_regs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
        if (inst[6:0] == 7'b0110111) begin
            return {inst[31:12], 12'h000};
        end
        case (inst[14:12])
            3'b000:  r = (reg_op && inst[30]) ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101:  r = inst[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic core_pkg::word_t make_op(input int fn, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2);
        logic [2:0] f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        logic       alt;
        alt = (fn == 1) || (fn == 7);
        return {1'b0, alt, 5'b0, rs2, rs1, f3[fn], rd, 7'b0110011};
    endfunction

    function automatic core_pkg::word_t make_imm(input logic [4:0] rd, input logic [4:0] rs1);
        logic [2:0]  f3;
        logic [11:0] imm;
        f3  = 3'(rand_bits(3));
        imm = 12'(rand_bits(12));
        if (f3 == 3'b001) begin
            imm[11:5] = 7'b0;
        end else if (f3 == 3'b101) begin
            imm[11:5] = {1'b0, imm[10], 5'b0};
        end
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // acceptance model shares its process with the run edge count
    always @(posedge clk) begin
        if (rst_n && !stall_i) begin
            run_edges = run_edges + 1;
            if (inst_valid_i && is_legal(inst_i)) begin
                exp_rd_q.push_back(inst_i[11:7]);
                exp_data_q.push_back(golden(inst_i));
                exp_tag_q.push_back(run_edges);
                if (inst_i[11:7] != 5'd0) begin
                    model_regs[inst_i[11:7]] = golden(inst_i);
                end
            end
        end
    end

    task automatic check_rd(input core_pkg::reg_addr_t got, input core_pkg::reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t wb_rd_o is x%0d, expected x%0d", $time, got, exp);
        end
    endtask

    task automatic check_word(input core_pkg::word_t got, input core_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t wb_data_o is %h, expected %h", $time, got, exp);
        end
    endtask

    // outputs are sampled mid cycle where they are stable
    always @(negedge clk) begin
        if (wb_valid_o === 1'b1) begin
            if (exp_rd_q.size() == 0) begin
                errors++;
                $display("[ERROR] %0t wb_valid_o pulsed with no instruction pending", $time);
            end else begin
                check_rd(wb_rd_o, exp_rd_q.pop_front());
                check_word(wb_data_o, exp_data_q.pop_front());
                // third cycle after acceptance is two running edges later
                if (run_edges - exp_tag_q.pop_front() != 2) begin
                    errors++;
                    $display("[ERROR] %0t result did not arrive in the third cycle", $time);
                end
            end
        end else if (wb_valid_o !== 1'b0) begin
            errors++;
            $display("[ERROR] %0t wb_valid_o is %b, expected a known level", $time,
                     wb_valid_o);
        end
    end

    task automatic send_inst(input core_pkg::word_t inst, input logic valid);
        int   tries;
        logic taken;
        tries = 0;
        taken = 1'b0;
        while (!taken) begin
            inst_i       <= inst;
            inst_valid_i <= valid;
            stall_i      <= stall_en && (2'(rand_bits(2)) == 2'd0);
            @(posedge clk);
            taken = !stall_i;
            #2;
            tries++;
            if (tries > 200) begin
                $display("timeout: instruction was never accepted by the pipeline");
                $display("FAIL: see errors above");
                $finish;
            end
        end
    endtask

    task automatic drain(input string name, input int errs_before);
        int cycles;
        inst_valid_i <= 1'b0;
        stall_i      <= 1'b0;
        cycles = 0;
        while (exp_rd_q.size() != 0) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > 50) begin
                $display("timeout: pipeline stopped producing results in test %s", name);
                $display("FAIL: see errors above");
                $finish;
            end
        end
        repeat (4) @(posedge clk);
        #2;
        tests++;
        $display("test %s: %0d errors", name, errors - errs_before);
    endtask

    initial begin
        int e0;
        logic [4:0] prev [2];
        lfsr = 16'd49;
        errors = 0;
        checks = 0;
        tests = 0;
        run_edges = 0;
        stall_en = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        rst_n = 1'b0;
        inst_valid_i = 1'b0;
        inst_i = '0;
        stall_i = 1'b0;
        e0 = errors;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        drain("reset", e0);

        e0 = errors;
        for (int i = 0; i < 80; i++) begin
            send_inst(make_op(i % 10, pick_reg(5), pick_reg(5), pick_reg(5)), 1'b1);
        end
        drain("register_ops", e0);

        e0 = errors;
        for (int i = 0; i < 80; i++) begin
            if (2'(rand_bits(2)) == 2'd0) begin
                send_inst({20'(rand_bits(20)), pick_reg(5), 7'b0110111}, 1'b1);
            end else begin
                send_inst(make_imm(pick_reg(5), pick_reg(5)), 1'b1);
            end
        end
        drain("immediates", e0);

        // small register set so every instruction hits a recent producer or x0
        e0 = errors;
        prev[0] = 5'd1;
        prev[1] = 5'd2;
        for (int i = 0; i < 100; i++) begin
            logic [4:0] rd;
            rd = pick_reg(2);
            send_inst(make_op(rand_bits(3), rd, prev[1'(rand_bits(1))], prev[0]), 1'b1);
            prev[1] = prev[0];
            prev[0] = rd;
        end
        drain("forwarding", e0);

        e0 = errors;
        stall_en = 1'b1;
        for (int i = 0; i < 100; i++) begin
            if (rand_bits(1)) begin
                send_inst(make_op(rand_bits(3), pick_reg(3), pick_reg(3), pick_reg(3)),
                          1'b1);
            end else begin
                send_inst(make_imm(pick_reg(3), pick_reg(3)), 1'b1);
            end
        end
        drain("stall", e0);
        stall_en = 1'b0;

        e0 = errors;
        for (int i = 0; i < 100; i++) begin
            case (2'(rand_bits(2)))
                2'd0: send_inst(rand_bits(32), 1'b0);
                2'd1: send_inst({25'(rand_bits(25)), 7'b1100011}, 1'b1);
                default: send_inst(make_op(rand_bits(3), pick_reg(3), pick_reg(3),
                                           pick_reg(3)), 1'b1);
            endcase
        end
        drain("bubbles_illegal", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
common/core_pkg.sv
decode/regfile.sv
decode/operand_fwd.sv
decode/decode_stage.sv
verilog/exe_stage.sv
verilog/int_pipe.sv
test/tb_int_pipe.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= -sv --timing
TOP       ?= tb_int_pipe
FILELIST  ?= src.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o sim_$(TOP)
	./$(OBJ_DIR)/sim_$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
